//--- all.f
hdl/cram_map_pkg.sv
hdl/cram_bus_pkg.sv
hdl/m68k_request_capture.sv
hdl/z80_request_capture.sv
hdl/cram_arbiter.sv
hdl/psram_phy.sv
hdl/cram_subsystem_top.sv
verification/tb_clock_gen.sv
verification/psram_model.sv
verification/tb_cram_subsystem.sv

//--- hdl/cram_arbiter.sv
//----------------------------------------------------------
// Cellular RAM arbiter
// Serves host, 68k read, 68k write and Z80 read in fixed
// priority, maps each client address into the chip and
// steers the returned data back to the requesting client
//----------------------------------------------------------
module cram_arbiter
	import cram_map_pkg::*;
	import cram_bus_pkg::*;
(
	input  logic                   sys_clk,
	input  logic                   reset_l_main,
	input  logic                   word_rd,
	input  logic                   word_wr,
	input  logic [word_addr_w-1:0] word_addr,
	input  logic [31:0]            word_data,
	output logic [31:0]            word_q,
	output logic                   word_busy,
	input  logic                   m68k_rd_pend,
	input  logic                   m68k_wr_pend,
	input  m68k_req_t              m68k_req,
	output logic                   m68k_rd_clear,
	output logic                   m68k_wr_clear,
	input  logic                   z80_pend,
	input  logic [z80_addr_w-1:0]  z80_addr,
	output logic                   z80_clear,
	output logic [7:0]             z80_dout,
	output logic [15:0]            prom_data,
	output logic [15:0]            sram_data,
	output logic [15:0]            work_ram,
	output logic                   prom_data_ready,
	output cram_cmd_t              cmd,
	output logic                   cmd_valid,
	input  logic                   cmd_done,
	input  logic [31:0]            rd_data
);

	typedef enum logic [1:0] {st_idle, st_busy, st_done} arb_state_t;

	arb_state_t             state;
	cram_channel_t          channel;
	cram_channel_t          next_ch;
	cram_cmd_t              next_cmd;
	logic                   grant;
	logic                   host_rnw;
	logic [word_addr_w-1:0] host_addr;
	logic [31:0]            host_data;
	logic                   z80_odd;

	// Priority pick and address translation
	always_comb begin
		grant    = 1'b1;
		next_ch  = ch_word;
		next_cmd = '0;
		next_cmd.be  = 4'hf;
		next_cmd.rnw = 1'b1;
		if (word_busy) begin
			next_cmd.addr  = {1'b0, host_addr[word_addr_w-1:1], 1'b0};
			next_cmd.wdata = host_data;
			next_cmd.rnw   = host_rnw;
			next_cmd.wide  = 1'b1;
		end else if (m68k_rd_pend) begin
			next_ch = ch_prom;
			case (m68k_req.rd_region)
				rgn_workram: begin
					next_cmd.addr = {1'b0, workram_base, m68k_req.addr[14:0], 1'b0};
					next_ch       = ch_workram;
				end
				rgn_backup: begin
					next_cmd.addr = {1'b0, backup_base, m68k_req.addr[14:0], 1'b0};
					next_ch       = ch_backup;
				end
				rgn_p1rom:
					next_cmd.addr = {5'b0, m68k_req.addr[18:0], 1'b0};
				rgn_p2rom:
					next_cmd.addr = {2'b0, m68k_req.p2_addr[21:0], 1'b0} + {1'b0, p2rom_base};
				default:
					next_cmd.addr = {1'b0, bios_base, m68k_req.addr[15:0], 1'b0};
			endcase
		end else if (m68k_wr_pend) begin
			if (m68k_req.wr_region == rgn_backup) begin
				next_cmd.addr = {1'b0, backup_base, m68k_req.addr[14:0], 1'b0};
				next_ch       = ch_backup;
			end else begin
				next_cmd.addr = {1'b0, workram_base, m68k_req.addr[14:0], 1'b0};
				next_ch       = ch_workram;
			end
			next_cmd.wdata = {2{m68k_req.wdata}};
			next_cmd.be    = {2{m68k_req.wr_mask}};
			next_cmd.rnw   = 1'b0;
		end else if (z80_pend) begin
			next_cmd.addr = {1'b0, z80_base, z80_addr[z80_addr_w-1:1], 1'b0};
			next_ch       = ch_z80;
		end else begin
			grant = 1'b0;
		end
	end

	always_ff @(posedge sys_clk or negedge reset_l_main) begin
		if (!reset_l_main) begin
			state           <= st_idle;
			channel         <= ch_word;
			cmd_valid       <= 1'b0;
			word_busy       <= 1'b0;
			prom_data_ready <= 1'b0;
			m68k_rd_clear   <= 1'b0;
			m68k_wr_clear   <= 1'b0;
			z80_clear       <= 1'b0;
		end else begin
			cmd_valid     <= 1'b0;
			m68k_rd_clear <= 1'b0;
			m68k_wr_clear <= 1'b0;
			z80_clear     <= 1'b0;
			if (m68k_req.as_rise)
				prom_data_ready <= 1'b0;
			if (word_rd || word_wr)
				word_busy <= 1'b1;
			case (state)
				st_idle: begin
					if (grant) begin
						state     <= st_busy;
						channel   <= next_ch;
						cmd_valid <= 1'b1;
						// Write data now sits in cmd, so the 68k may queue the next one
						m68k_wr_clear <= !next_cmd.rnw && next_ch != ch_word;
					end
				end
				st_busy: begin
					if (cmd_done) begin
						state <= st_done;
						case (channel)
							ch_word:
								word_busy <= 1'b0;
							ch_z80:
								z80_clear <= 1'b1;
							default: begin
								if (cmd.rnw) begin
									m68k_rd_clear   <= 1'b1;
									prom_data_ready <= 1'b1;
								end
							end
						endcase
					end
				end
				// Gives the captures a cycle to drop their flags
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (word_rd || word_wr) begin
			host_rnw  <= word_rd;
			host_addr <= word_addr;
			host_data <= word_data;
		end
		if (state == st_idle && grant) begin
			cmd     <= next_cmd;
			z80_odd <= z80_addr[0];
		end
		if (state == st_busy && cmd_done && cmd.rnw) begin
			case (channel)
				ch_word:    word_q    <= rd_data;
				ch_backup:  sram_data <= rd_data[15:0];
				ch_workram: work_ram  <= rd_data[15:0];
				ch_z80:     z80_dout  <= z80_odd ? rd_data[15:8] : rd_data[7:0];
				default:    prom_data <= rd_data[15:0];
			endcase
		end
	end

	// The bus engine only reports back on an issued command
	a_done_while_busy: assert property (
		@(posedge sys_clk) disable iff (!reset_l_main)
		cmd_done |-> state == st_busy);

endmodule

//--- hdl/cram_bus_pkg.sv
//----------------------------------------------------------
// Cellular RAM bus types
// Client request record, arbiter command, PSRAM pin group
// and the access timing of the chip
//----------------------------------------------------------
package cram_bus_pkg;

	import cram_map_pkg::*;

	// Chip timing, in sys_clk cycles
	localparam int wait_cycles     = 3;
	localparam int recovery_cycles = 1;

	// Where returned data goes
	typedef enum logic [2:0] {
		ch_word    = 3'd0,
		ch_backup  = 3'd1,
		ch_z80     = 3'd2,
		ch_prom    = 3'd3,
		ch_workram = 3'd4
	} cram_channel_t;

	// One access as handed to the bus engine
	typedef struct packed {
		logic [ram_addr_w-1:0] addr;
		logic [31:0]           wdata;
		logic [3:0]            be;
		logic                  rnw;
		logic                  wide;
	} cram_cmd_t;

	// Latched 68k request, as_rise marks the end of a bus cycle
	typedef struct packed {
		logic                   as_rise;
		logic [m68k_addr_w-1:0] addr;
		logic [p2_addr_w-1:0]   p2_addr;
		logic [15:0]            wdata;
		logic [1:0]             wr_mask;
		m68k_region_t           wr_region;
		m68k_region_t           rd_region;
	} m68k_req_t;

	typedef struct packed {
		logic [ram_addr_w-1:0] addr;
		logic                  adv_n;
		logic                  ce_n;
		logic                  oe_n;
		logic                  we_n;
		logic                  ub_n;
		logic                  lb_n;
	} psram_pins_t;

endpackage

//--- hdl/cram_map_pkg.sv
//----------------------------------------------------------
// Cellular RAM memory map
// Address widths of the chip and of each client, plus the
// prefixes that place every console region in the chip
//----------------------------------------------------------
package cram_map_pkg;

	// Address widths
	localparam int ram_addr_w  = 25;
	localparam int word_addr_w = 24;
	localparam int m68k_addr_w = 20;
	localparam int p2_addr_w   = 24;
	localparam int z80_addr_w  = 19;

	// Word address layout of the chip
	//   000000 - 0FFFFF  P1 ROM
	//   100000 - 8FFFFF  P2 ROM (cartridge)
	//   A00000 - A1FFFF  system ROM
	//   A20000 - A2FFFF  work RAM
	//   A30000 - A3FFFF  backup RAM
	//   F80000 - FFFFFF  Z80 ROM
	localparam logic [23:0] p2rom_base   = 24'h10_0000;
	localparam logic [6:0]  bios_base    = 7'b101_0000;
	localparam logic [7:0]  workram_base = 8'b1010_0010;
	localparam logic [7:0]  backup_base  = 8'b1010_0011;
	localparam logic [4:0]  z80_base     = 5'b1_1111;

	// Region a 68k access falls into
	typedef enum logic [2:0] {
		rgn_workram,
		rgn_backup,
		rgn_p1rom,
		rgn_p2rom,
		rgn_bios
	} m68k_region_t;

endpackage

//--- hdl/cram_subsystem_top.sv
//----------------------------------------------------------
// Cellular RAM subsystem
// Client request captures, arbiter and PSRAM bus engine
// sharing one 16-bit chip
//----------------------------------------------------------
module cram_subsystem_top
	import cram_map_pkg::*;
	import cram_bus_pkg::*;
(
	input  logic                   sys_clk,
	input  logic                   reset_l_main,
	input  logic                   core_run,
	// Host word port
	input  logic                   word_rd,
	input  logic                   word_wr,
	input  logic [word_addr_w-1:0] word_addr,
	input  logic [31:0]            word_data,
	output logic [31:0]            word_q,
	output logic                   word_busy,
	// 68k bus
	input  logic [m68k_addr_w-1:0] m68k_addr,
	input  logic [p2_addr_w-1:0]   p2rom_addr,
	input  logic [15:0]            m68k_data,
	input  logic                   n_as,
	input  logic                   n_romoe,
	input  logic                   n_portoe,
	input  logic                   n_sromoe,
	input  logic                   n_sramoe,
	input  logic                   n_workram,
	input  logic                   n_bwl,
	input  logic                   n_bwu,
	input  logic                   n_wwl,
	input  logic                   n_wwu,
	output logic [15:0]            prom_data,
	output logic [15:0]            sram_data,
	output logic [15:0]            work_ram,
	output logic                   prom_data_ready,
	// Z80 bus
	input  logic [z80_addr_w-1:0]  z80_addr,
	input  logic                   n_sdmrd,
	input  logic                   n_sdrom,
	output logic [7:0]             z80_dout,
	output logic                   z80_ready,
	// PSRAM chip
	output psram_pins_t            pins,
	output logic [15:0]            dq_out,
	output logic                   dq_oe,
	input  logic [15:0]            dq_in
);

	logic        m68k_rd_pend;
	logic        m68k_wr_pend;
	logic        m68k_rd_clear;
	logic        m68k_wr_clear;
	m68k_req_t   m68k_req;
	logic        z80_pend;
	logic        z80_clear;
	cram_cmd_t   cmd;
	logic        cmd_valid;
	logic        cmd_done;
	logic [31:0] rd_data;

	m68k_request_capture u_m68k_capture (
		.sys_clk      (sys_clk),
		.reset_l_main (reset_l_main),
		.core_run     (core_run),
		.m68k_addr    (m68k_addr),
		.p2rom_addr   (p2rom_addr),
		.m68k_data    (m68k_data),
		.n_as         (n_as),
		.n_romoe      (n_romoe),
		.n_portoe     (n_portoe),
		.n_sromoe     (n_sromoe),
		.n_sramoe     (n_sramoe),
		.n_workram    (n_workram),
		.n_bwl        (n_bwl),
		.n_bwu        (n_bwu),
		.n_wwl        (n_wwl),
		.n_wwu        (n_wwu),
		.rd_clear     (m68k_rd_clear),
		.wr_clear     (m68k_wr_clear),
		.rd_pend      (m68k_rd_pend),
		.wr_pend      (m68k_wr_pend),
		.req          (m68k_req)
	);

	z80_request_capture u_z80_capture (
		.sys_clk      (sys_clk),
		.reset_l_main (reset_l_main),
		.core_run     (core_run),
		.n_sdmrd      (n_sdmrd),
		.n_sdrom      (n_sdrom),
		.clear        (z80_clear),
		.pend         (z80_pend),
		.z80_ready    (z80_ready)
	);

	cram_arbiter u_arbiter (
		.sys_clk         (sys_clk),
		.reset_l_main    (reset_l_main),
		.word_rd         (word_rd),
		.word_wr         (word_wr),
		.word_addr       (word_addr),
		.word_data       (word_data),
		.word_q          (word_q),
		.word_busy       (word_busy),
		.m68k_rd_pend    (m68k_rd_pend),
		.m68k_wr_pend    (m68k_wr_pend),
		.m68k_req        (m68k_req),
		.m68k_rd_clear   (m68k_rd_clear),
		.m68k_wr_clear   (m68k_wr_clear),
		.z80_pend        (z80_pend),
		.z80_addr        (z80_addr),
		.z80_clear       (z80_clear),
		.z80_dout        (z80_dout),
		.prom_data       (prom_data),
		.sram_data       (sram_data),
		.work_ram        (work_ram),
		.prom_data_ready (prom_data_ready),
		.cmd             (cmd),
		.cmd_valid       (cmd_valid),
		.cmd_done        (cmd_done),
		.rd_data         (rd_data)
	);

	psram_phy u_phy (
		.sys_clk      (sys_clk),
		.reset_l_main (reset_l_main),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cmd_done     (cmd_done),
		.rd_data      (rd_data),
		.pins         (pins),
		.dq_out       (dq_out),
		.dq_oe        (dq_oe),
		.dq_in        (dq_in)
	);

endmodule

//--- hdl/m68k_request_capture.sv
//----------------------------------------------------------
// 68k request capture
// Detects the start of 68k reads and writes from the chip
// selects and write strobes, latches address and data and
// keeps a pending flag per direction for the arbiter
//----------------------------------------------------------
module m68k_request_capture
	import cram_map_pkg::*;
	import cram_bus_pkg::*;
(
	input  logic                   sys_clk,
	input  logic                   reset_l_main,
	input  logic                   core_run,
	input  logic [m68k_addr_w-1:0] m68k_addr,
	input  logic [p2_addr_w-1:0]   p2rom_addr,
	input  logic [15:0]            m68k_data,
	input  logic                   n_as,
	input  logic                   n_romoe,
	input  logic                   n_portoe,
	input  logic                   n_sromoe,
	input  logic                   n_sramoe,
	input  logic                   n_workram,
	input  logic                   n_bwl,
	input  logic                   n_bwu,
	input  logic                   n_wwl,
	input  logic                   n_wwu,
	input  logic                   rd_clear,
	input  logic                   wr_clear,
	output logic                   rd_pend,
	output logic                   wr_pend,
	output m68k_req_t              req
);

	logic                   rd_sig;
	logic                   wr_sig;
	logic                   rd_sig_q;
	logic                   wr_sig_q;
	logic                   n_as_q;
	logic                   rd_edge;
	logic                   wr_edge;
	logic                   wr_backup;
	logic                   as_rise;
	m68k_region_t           rd_region;
	logic [m68k_addr_w-1:0] lat_addr;
	logic [p2_addr_w-1:0]   lat_p2;
	logic [15:0]            lat_data;
	logic [1:0]             lat_mask;
	m68k_region_t           lat_wr_region;
	m68k_region_t           lat_rd_region;

	assign rd_sig    = ~&{n_romoe, n_portoe, n_sromoe, n_sramoe, n_workram};
	assign wr_sig    = ~&{n_bwl, n_bwu, n_wwl, n_wwu};
	assign rd_edge   = core_run && rd_sig && !rd_sig_q;
	assign wr_edge   = core_run && wr_sig && !wr_sig_q;
	assign wr_backup = ~&{n_bwl, n_bwu};

	// Work RAM select wins, the system ROM is what is left
	always_comb begin
		casez ({n_workram, n_sramoe, n_romoe, n_portoe})
			4'b0???: rd_region = rgn_workram;
			4'b10??: rd_region = rgn_backup;
			4'b110?: rd_region = rgn_p1rom;
			4'b1110: rd_region = rgn_p2rom;
			default: rd_region = rgn_bios;
		endcase
	end

	always_ff @(posedge sys_clk or negedge reset_l_main) begin
		if (!reset_l_main) begin
			rd_sig_q <= 1'b0;
			wr_sig_q <= 1'b0;
			n_as_q   <= 1'b1;
			as_rise  <= 1'b0;
			rd_pend  <= 1'b0;
			wr_pend  <= 1'b0;
		end else if (!core_run) begin
			// Console held in reset, drop anything outstanding
			rd_sig_q <= 1'b0;
			wr_sig_q <= 1'b0;
			n_as_q   <= 1'b1;
			as_rise  <= 1'b0;
			rd_pend  <= 1'b0;
			wr_pend  <= 1'b0;
		end else begin
			rd_sig_q <= rd_sig;
			wr_sig_q <= wr_sig;
			n_as_q   <= n_as;
			as_rise  <= n_as && !n_as_q;
			// A fresh edge takes priority over a clear in the same cycle
			if (rd_clear)
				rd_pend <= 1'b0;
			if (rd_edge)
				rd_pend <= 1'b1;
			if (wr_clear)
				wr_pend <= 1'b0;
			if (wr_edge)
				wr_pend <= 1'b1;
		end
	end

	// Address is taken with the strobe edge that opens the request
	always_ff @(posedge sys_clk) begin
		if (rd_edge) begin
			lat_addr      <= m68k_addr;
			lat_p2        <= p2rom_addr;
			lat_rd_region <= rd_region;
		end
		if (wr_edge) begin
			lat_addr      <= m68k_addr;
			lat_data      <= m68k_data;
			lat_mask      <= wr_backup ? {~n_bwu, ~n_bwl} : {~n_wwu, ~n_wwl};
			lat_wr_region <= wr_backup ? rgn_backup : rgn_workram;
		end
	end

	assign req = '{as_rise: as_rise, addr: lat_addr, p2_addr: lat_p2, wdata: lat_data,
		wr_mask: lat_mask, wr_region: lat_wr_region, rd_region: lat_rd_region};

	// Arbiter only completes reads that were requested
	a_rd_clear_pending: assert property (
		@(posedge sys_clk) disable iff (!reset_l_main) rd_clear |-> rd_pend);

endmodule

//--- hdl/psram_phy.sv
//----------------------------------------------------------
// PSRAM bus engine
// Runs one asynchronous access on the chip: address latch,
// access wait, one or two data beats and recovery, then
// reports completion with the read data
//----------------------------------------------------------
module psram_phy
	import cram_map_pkg::*;
	import cram_bus_pkg::*;
(
	input  logic        sys_clk,
	input  logic        reset_l_main,
	input  cram_cmd_t   cmd,
	input  logic        cmd_valid,
	output logic        cmd_done,
	output logic [31:0] rd_data,
	output psram_pins_t pins,
	output logic [15:0] dq_out,
	output logic        dq_oe,
	input  logic [15:0] dq_in
);

	typedef enum logic [2:0] {ph_idle, ph_addr, ph_wait, ph_beat, ph_rec} phase_t;

	phase_t    phase;
	logic [1:0] cnt;
	logic       beat;
	cram_cmd_t  cmd_q;
	logic       in_beat;

	assign in_beat = phase == ph_beat;

	always_ff @(posedge sys_clk or negedge reset_l_main) begin
		if (!reset_l_main) begin
			phase <= ph_idle;
			cnt   <= 2'd0;
			beat  <= 1'b0;
		end else begin
			case (phase)
				ph_idle: begin
					if (cmd_valid)
						phase <= ph_addr;
				end
				ph_addr: begin
					phase <= ph_wait;
					cnt   <= 2'd0;
				end
				ph_wait: begin
					if (cnt == 2'(wait_cycles - 1)) begin
						phase <= ph_beat;
						beat  <= 1'b0;
					end else begin
						cnt <= cnt + 2'd1;
					end
				end
				ph_beat: begin
					// Wide access takes the high word on a second beat
					if (cmd_q.wide && !beat) begin
						beat <= 1'b1;
					end else begin
						phase <= ph_rec;
						cnt   <= 2'd0;
					end
				end
				default: begin
					if (cnt == 2'(recovery_cycles - 1))
						phase <= ph_idle;
					else
						cnt <= cnt + 2'd1;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (phase == ph_idle && cmd_valid)
			cmd_q <= cmd;
		if (in_beat && cmd_q.rnw) begin
			if (beat)
				rd_data[31:16] <= dq_in;
			else
				rd_data[15:0] <= dq_in;
		end
	end

	assign cmd_done = phase == ph_rec && cnt == 2'(recovery_cycles - 1);

	// Second beat addresses the odd word of the pair
	assign pins.addr  = in_beat ? {cmd_q.addr[ram_addr_w-1:1], beat} : cmd_q.addr;
	assign pins.adv_n = phase != ph_addr;
	assign pins.ce_n  = !(phase inside {ph_addr, ph_wait, ph_beat});
	assign pins.oe_n  = !(in_beat && cmd_q.rnw);
	assign pins.we_n  = !(in_beat && !cmd_q.rnw);
	assign pins.ub_n  = !(in_beat && cmd_q.be[{beat, 1'b1}]);
	assign pins.lb_n  = !(in_beat && cmd_q.be[{beat, 1'b0}]);

	assign dq_oe  = in_beat && !cmd_q.rnw;
	assign dq_out = beat ? cmd_q.wdata[31:16] : cmd_q.wdata[15:0];

	// One access on the chip at a time, a command arriving mid-access is lost
	a_cmd_while_idle: assert property (
		@(posedge sys_clk) disable iff (!reset_l_main)
		cmd_valid |-> phase == ph_idle);

endmodule

//--- hdl/z80_request_capture.sv
//----------------------------------------------------------
// Z80 request capture
// Starts a ROM read when both Z80 strobes go low and holds
// the CPU off with the ready level until data is back
//----------------------------------------------------------
module z80_request_capture (
	input  logic sys_clk,
	input  logic reset_l_main,
	input  logic core_run,
	input  logic n_sdmrd,
	input  logic n_sdrom,
	input  logic clear,
	output logic pend,
	output logic z80_ready
);

	logic rd_sig;
	logic rd_sig_q;

	assign rd_sig = !n_sdmrd && !n_sdrom;

	always_ff @(posedge sys_clk or negedge reset_l_main) begin
		if (!reset_l_main) begin
			rd_sig_q  <= 1'b0;
			pend      <= 1'b0;
			z80_ready <= 1'b1;
		end else if (!core_run) begin
			rd_sig_q  <= 1'b0;
			pend      <= 1'b0;
			z80_ready <= 1'b1;
		end else begin
			rd_sig_q <= rd_sig;
			if (clear) begin
				pend      <= 1'b0;
				z80_ready <= 1'b1;
			end
			// New read, stall the CPU right away
			if (rd_sig && !rd_sig_q) begin
				pend      <= 1'b1;
				z80_ready <= 1'b0;
			end
		end
	end

	// Arbiter only releases a CPU that it holds
	a_clear_while_stalled: assert property (
		@(posedge sys_clk) disable iff (!reset_l_main) clear |-> !z80_ready);

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_cram_subsystem -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"
if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1

//--- verification/cram_stim.txt
// op sel addr data expect, all hex, op 1 host write, 2 host read, 3 68k read, 4 68k write
// 5 Z80 read, 6 68k and Z80 read at once (data is the Z80 address), 0 ends the list
01 00 00000100 11223344 00000000
01 00 00000202 cafef00d 00000000
02 00 00000100 00000000 11223344
02 00 00000202 00000000 cafef00d
01 00 0012468a 5a5aa5c3 00000000
01 00 00a1e014 0000b105 00000000
01 00 00a2468a 77778899 00000000
01 00 00a31578 4444bc0d 00000000
01 00 00f81234 0000c37e 00000000
03 02 00000080 00000000 00003344
03 03 00012345 00000000 0000a5c3
03 04 0000f00a 00000000 0000b105
03 00 00012345 00000000 00008899
03 01 00000abc 00000000 0000bc0d
04 01 00012345 000012ee 00000000
04 12 00000abc 00005d34 00000000
02 00 00a2468a 00000000 777788ee
02 00 00a31578 00000000 44445d0d
03 00 00012345 00000000 000088ee
05 00 00001235 00000000 000000c3
05 00 00001234 00000000 0000007e
06 02 00000080 00001235 00c33344
00 00 00000000 00000000 00000000

//--- verification/psram_model.sv
//----------------------------------------------------------
// PSRAM behavioral model
// Sparse 16-bit word array behind the async pin protocol,
// byte lanes selected by ub_n and lb_n
//----------------------------------------------------------
module psram_model
	import cram_map_pkg::*;
	import cram_bus_pkg::*;
(
	input  logic        sys_clk,
	input  psram_pins_t pins,
	input  logic [15:0] dq_out,
	input  logic        dq_oe,
	output logic [15:0] dq_in
);

	// Only words that were written are stored
	logic [15:0] mem [logic [ram_addr_w-1:0]];

	// Content of a word never written, mixes in every address bit
	function automatic logic [15:0] fill_word(input logic [ram_addr_w-1:0] a);
		return a[15:0] ^ {7'b0, a[ram_addr_w-1:16]} ^ 16'h5a5a;
	endfunction

	function automatic logic [15:0] peek(input logic [ram_addr_w-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return fill_word(a);
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
		input logic [15:0] new_w, input logic ub_n, input logic lb_n);
		return {ub_n ? old_w[15:8] : new_w[15:8], lb_n ? old_w[7:0] : new_w[7:0]};
	endfunction

	always @(posedge sys_clk) begin
		if (!pins.ce_n && !pins.we_n && dq_oe)
			mem[pins.addr] = merge_bytes(peek(pins.addr), dq_out, pins.ub_n, pins.lb_n);
	end

	// Chip output settles half a cycle into the beat
	initial begin
		dq_in <= 16'h0000;
		forever begin
			@(negedge sys_clk);
			if (!pins.ce_n && !pins.oe_n)
				dq_in <= merge_bytes(16'h0000, peek(pins.addr), pins.ub_n, pins.lb_n);
			else if (dq_oe)
				dq_in <= dq_out;
			else
				dq_in <= 16'h0000;
		end
	end

endmodule

//--- verification/tb_clock_gen.sv
//----------------------------------------------------------
// Testbench clock and reset
// Free running sys_clk with period 4 and an active low
// reset held for the first 3 rising edges
//----------------------------------------------------------
module tb_clock_gen (
	output logic sys_clk,
	output logic reset_l_main
);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	initial begin
		reset_l_main <= 1'b0;
		repeat (3) @(posedge sys_clk);
		reset_l_main <= 1'b1;
	end

endmodule

//--- verification/tb_cram_subsystem.sv
//----------------------------------------------------------
// Cellular RAM subsystem testbench
// Replays host, 68k and Z80 operations from the stimulus
// file against the subsystem and a PSRAM model, comparing
// every returned value with the expected one
//----------------------------------------------------------
module tb_cram_subsystem
	import cram_map_pkg::*;
	import cram_bus_pkg::*;
();

	localparam int stim_words     = 160;
	localparam int timeout_cycles = 200;

	typedef enum {
		host_idle,
		m68k_data_ready,
		m68k_data_cleared,
		z80_stalled,
		z80_released,
		write_beat,
		reset_done
	} wait_cond_t;

	logic                   sys_clk;
	logic                   reset_l_main;
	logic                   core_run;
	logic                   word_rd;
	logic                   word_wr;
	logic [word_addr_w-1:0] word_addr;
	logic [31:0]            word_data;
	logic [31:0]            word_q;
	logic                   word_busy;
	logic [m68k_addr_w-1:0] m68k_addr;
	logic [p2_addr_w-1:0]   p2rom_addr;
	logic [15:0]            m68k_data;
	logic                   n_as;
	logic                   n_romoe;
	logic                   n_portoe;
	logic                   n_sromoe;
	logic                   n_sramoe;
	logic                   n_workram;
	logic                   n_bwl;
	logic                   n_bwu;
	logic                   n_wwl;
	logic                   n_wwu;
	logic [15:0]            prom_data;
	logic [15:0]            sram_data;
	logic [15:0]            work_ram;
	logic                   prom_data_ready;
	logic [z80_addr_w-1:0]  z80_addr;
	logic                   n_sdmrd;
	logic                   n_sdrom;
	logic [7:0]             z80_dout;
	logic                   z80_ready;
	psram_pins_t            pins;
	logic [15:0]            dq_out;
	logic                   dq_oe;
	logic [15:0]            dq_in;

	logic [31:0] stim_mem [0:stim_words-1];
	int          error_count;
	int          timeout_count;
	bit          aborted;

	tb_clock_gen u_clock (.*);

	psram_model u_psram (.*);

	cram_subsystem_top uut (.*);

	function automatic bit cond_met(input wait_cond_t cond);
		case (cond)
			host_idle:         return !word_busy;
			m68k_data_ready:   return prom_data_ready;
			m68k_data_cleared: return !prom_data_ready;
			z80_stalled:       return !z80_ready;
			z80_released:      return z80_ready;
			write_beat:        return dq_oe;
			default:           return reset_l_main;
		endcase
	endfunction

	// Outputs are looked at on the falling edge, half a cycle after they change
	task automatic wait_for(input wait_cond_t cond);
		int n;
		bit hit;
		n   = 0;
		hit = 0;
		if (!aborted) begin
			while (!hit && n < timeout_cycles) begin
				@(negedge sys_clk);
				hit = cond_met(cond);
				n++;
			end
			if (!hit) begin
				timeout_count++;
				aborted = 1;
				$display("Timeout at time %0t: waited %0d cycles for %s and it never came",
					$time, timeout_cycles, cond.name());
			end
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			error_count++;
			$display("FAILED at time %0t: %s gave %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [15:0] m68k_result(input logic [7:0] sel);
		case (sel)
			8'h00:   return work_ram;
			8'h01:   return sram_data;
			default: return prom_data;
		endcase
	endfunction

	// Select codes 0 work RAM, 1 backup RAM, 2 P1 ROM, 3 P2 ROM, 4 BIOS
	task automatic drive_read_select(input logic [7:0] sel, input logic level);
		case (sel)
			8'h00:   n_workram <= level;
			8'h01:   n_sramoe  <= level;
			8'h02:   n_romoe   <= level;
			8'h03:   n_portoe  <= level;
			default: n_sromoe  <= level;
		endcase
	endtask

	// Bit 4 picks backup RAM, bits 1 and 0 are the upper and lower byte
	task automatic drive_write_strobes(input logic [7:0] sel, input logic active);
		if (sel[4]) begin
			n_bwu <= !(active && sel[1]);
			n_bwl <= !(active && sel[0]);
		end else begin
			n_wwu <= !(active && sel[1]);
			n_wwl <= !(active && sel[0]);
		end
	endtask

	task automatic start_m68k_read(input logic [7:0] sel, input logic [31:0] addr);
		m68k_addr  <= addr[m68k_addr_w-1:0];
		p2rom_addr <= addr[p2_addr_w-1:0];
		n_as       <= 1'b0;
		drive_read_select(sel, 1'b0);
	endtask

	task automatic end_m68k_read(input logic [7:0] sel);
		n_as <= 1'b1;
		drive_read_select(sel, 1'b1);
	endtask

	task automatic start_z80_read(input logic [31:0] addr);
		z80_addr <= addr[z80_addr_w-1:0];
		n_sdmrd  <= 1'b0;
		n_sdrom  <= 1'b0;
	endtask

	task automatic end_z80_read();
		n_sdmrd <= 1'b1;
		n_sdrom <= 1'b1;
	endtask

	task automatic host_access(input logic write, input logic [31:0] addr,
		input logic [31:0] data);
		@(posedge sys_clk);
		word_addr <= addr[word_addr_w-1:0];
		word_data <= data;
		word_wr   <= write;
		word_rd   <= !write;
		@(posedge sys_clk);
		word_wr <= 1'b0;
		word_rd <= 1'b0;
		wait_for(host_idle);
	endtask

	task automatic read_m68k(input logic [7:0] sel, input logic [31:0] addr,
		input logic [31:0] exp);
		@(posedge sys_clk);
		start_m68k_read(sel, addr);
		wait_for(m68k_data_ready);
		if (!aborted)
			check_value($sformatf("68k read, select %0d, address %h", sel, addr),
				32'(m68k_result(sel)), 32'(exp[15:0]));
		@(posedge sys_clk);
		end_m68k_read(sel);
		// Ready must drop again before the next read can be seen rising
		wait_for(m68k_data_cleared);
	endtask

	task automatic write_m68k(input logic [7:0] sel, input logic [31:0] addr,
		input logic [31:0] data);
		@(posedge sys_clk);
		m68k_addr <= addr[m68k_addr_w-1:0];
		m68k_data <= data[15:0];
		n_as      <= 1'b0;
		drive_write_strobes(sel, 1'b1);
		wait_for(write_beat);
		@(posedge sys_clk);
		n_as <= 1'b1;
		drive_write_strobes(sel, 1'b0);
	endtask

	task automatic read_z80(input logic [31:0] addr, input logic [31:0] exp);
		@(posedge sys_clk);
		start_z80_read(addr);
		wait_for(z80_stalled);
		wait_for(z80_released);
		if (!aborted)
			check_value($sformatf("Z80 read at %h", addr), 32'(z80_dout), 32'(exp[7:0]));
		@(posedge sys_clk);
		end_z80_read();
	endtask

	// Both reads start on the same edge, the 68k one is served first
	task automatic read_m68k_and_z80(input logic [7:0] sel, input logic [31:0] addr,
		input logic [31:0] z_addr, input logic [31:0] exp);
		@(posedge sys_clk);
		start_m68k_read(sel, addr);
		start_z80_read(z_addr);
		wait_for(z80_stalled);
		wait_for(m68k_data_ready);
		if (!aborted)
			check_value($sformatf("Joint 68k read at %h", addr),
				32'(m68k_result(sel)), 32'(exp[15:0]));
		wait_for(z80_released);
		if (!aborted)
			check_value($sformatf("Joint Z80 read at %h", z_addr),
				32'(z80_dout), 32'(exp[23:16]));
		@(posedge sys_clk);
		end_m68k_read(sel);
		end_z80_read();
		wait_for(m68k_data_cleared);
	endtask

	initial begin
		int          idx;
		logic [7:0]  op;
		logic [7:0]  sel;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_val;

		error_count   = 0;
		timeout_count = 0;
		aborted       = 0;
		core_run   <= 1'b0;
		word_rd    <= 1'b0;
		word_wr    <= 1'b0;
		word_addr  <= '0;
		word_data  <= '0;
		m68k_addr  <= '0;
		p2rom_addr <= '0;
		m68k_data  <= '0;
		n_as       <= 1'b1;
		n_romoe    <= 1'b1;
		n_portoe   <= 1'b1;
		n_sromoe   <= 1'b1;
		n_sramoe   <= 1'b1;
		n_workram  <= 1'b1;
		n_bwl      <= 1'b1;
		n_bwu      <= 1'b1;
		n_wwl      <= 1'b1;
		n_wwu      <= 1'b1;
		z80_addr   <= '0;
		n_sdmrd    <= 1'b1;
		n_sdrom    <= 1'b1;

		for (idx = 0; idx < stim_words; idx++)
			stim_mem[idx] = '0;
		$readmemh("verification/cram_stim.txt", stim_mem);

		wait_for(reset_done);
		check_value("word_busy after reset", 32'(word_busy), 32'd0);
		check_value("prom_data_ready after reset", 32'(prom_data_ready), 32'd0);
		check_value("z80_ready after reset", 32'(z80_ready), 32'd1);
		check_value("PSRAM ce_n after reset", 32'(pins.ce_n), 32'd1);
		@(posedge sys_clk);
		core_run <= 1'b1;

		idx = 0;
		op  = stim_mem[0][7:0];
		if (op == 8'h00) begin
			error_count++;
			$display("The stimulus file holds no operations");
		end
		while (op != 8'h00 && !aborted && idx + 5 <= stim_words) begin
			sel     = stim_mem[idx+1][7:0];
			addr    = stim_mem[idx+2];
			data    = stim_mem[idx+3];
			exp_val = stim_mem[idx+4];
			case (op)
				8'h01: host_access(1'b1, addr, data);
				8'h02: begin
					host_access(1'b0, addr, 32'h0);
					if (!aborted)
						check_value($sformatf("Host read at %h", addr), word_q, exp_val);
				end
				8'h03: read_m68k(sel, addr, exp_val);
				8'h04: write_m68k(sel, addr, data);
				8'h05: read_z80(addr, exp_val);
				8'h06: read_m68k_and_z80(sel, addr, data, exp_val);
				default: begin
					error_count++;
					$display("Unknown operation code %h in stimulus entry %0d", op, idx / 5);
				end
			endcase
			idx += 5;
			op = (idx < stim_words) ? stim_mem[idx][7:0] : 8'h00;
		end

		$display("Failed checks: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
